// ==== hdl/port_wr_pkg.sv ====
package port_wr_pkg;

    // one word on the write and transfer buses
    typedef logic [15:0] data_t;

    // destination port number
    typedef logic [3:0] port_t;

    // packet priority
    typedef logic [2:0] prior_t;

    // data length in words, header word not included
    typedef logic [8:0] len_t;

    // largest length a header can carry
    localparam int MAX_PKT_WORDS = 511;

    // default data memory depth in words, power of two
    localparam int BUF_DEPTH_DEF = 1024;

    // default number of committed headers waiting for a grant
    localparam int HDR_DEPTH_DEF = 4;

    // header word layout
    localparam int HDR_PORT_LSB  = 0;
    localparam int HDR_PRIOR_LSB = 4;
    localparam int HDR_LEN_LSB   = 7;

endpackage

// ==== hdl/port_wr_header_decode.sv ====
module port_wr_header_decode (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                wr_sop,
    input  logic                wr_eop,
    input  logic                wr_vld,
    input  port_wr_pkg::data_t  wr_data,
    output port_wr_pkg::data_t  wr_word,
    output logic                wr_word_en,
    output logic                pkt_commit,
    output logic                pkt_drop,
    output port_wr_pkg::port_t  hdr_port,
    output port_wr_pkg::prior_t hdr_prior,
    output port_wr_pkg::len_t   hdr_len
);

    typedef enum logic [1:0] {
        IDLE,
        HEADER,
        DATA
    } state_t;

    // one bit wider than a length so an over-long packet can be seen
    typedef logic [$bits(port_wr_pkg::len_t):0] cnt_t;

    state_t state;
    cnt_t   data_cnt;
    cnt_t   cnt_nxt;
    cnt_t   len_ext;
    logic   take_word;
    logic   keep_word;
    logic   commit_nxt;
    logic   drop_nxt;

    assign len_ext = {1'b0, hdr_len};

    // count saturates at length + 1, enough to decide a mismatch
    assign take_word = (state == DATA) && wr_vld && (data_cnt <= len_ext);

    // only words inside the declared length reach the buffer
    assign keep_word = (state == DATA) && wr_vld && (data_cnt < len_ext);

    // a word arriving together with wr_eop still counts
    assign cnt_nxt = data_cnt + cnt_t'(take_word);

    assign commit_nxt = (state == DATA) && wr_eop && (cnt_nxt == len_ext);

    // an eop before any data word is a broken packet as well
    assign drop_nxt = (state != IDLE) && wr_eop && !commit_nxt;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state <= IDLE;
        end
        else
        begin
            case (state)
                IDLE:
                begin
                    if (wr_sop)
                        state <= HEADER;
                end
                HEADER:
                begin
                    if (wr_eop)
                        state <= IDLE;
                    else if (wr_vld)
                        state <= DATA;
                end
                DATA:
                begin
                    if (wr_eop)
                        state <= IDLE;
                end
                default:
                begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            data_cnt   <= '0;
            wr_word_en <= 1'b0;
            pkt_commit <= 1'b0;
            pkt_drop   <= 1'b0;
        end
        else
        begin
            if (state == HEADER)
                data_cnt <= '0;
            else
                data_cnt <= cnt_nxt;
            wr_word_en <= keep_word;
            pkt_commit <= commit_nxt;
            pkt_drop   <= drop_nxt;
        end
    end

    // header fields stay put until the next header word
    always_ff @(posedge clk)
    begin
        if (keep_word)
            wr_word <= wr_data;
        if ((state == HEADER) && wr_vld)
        begin
            hdr_len   <= wr_data[port_wr_pkg::HDR_LEN_LSB +: $bits(port_wr_pkg::len_t)];
            hdr_prior <= wr_data[port_wr_pkg::HDR_PRIOR_LSB +: $bits(port_wr_pkg::prior_t)];
            hdr_port  <= wr_data[port_wr_pkg::HDR_PORT_LSB +: $bits(port_wr_pkg::port_t)];
        end
    end

endmodule

// ==== hdl/port_wr_packet_buffer.sv ====
module port_wr_packet_buffer #(
    parameter int BUF_DEPTH = 1024,
    parameter int HDR_DEPTH = 4
) (
    input  logic                clk,
    input  logic                rst_n,
    input  port_wr_pkg::data_t  wr_word,
    input  logic                wr_word_en,
    input  logic                pkt_commit,
    input  logic                pkt_drop,
    input  port_wr_pkg::port_t  hdr_port,
    input  port_wr_pkg::prior_t hdr_prior,
    input  port_wr_pkg::len_t   hdr_len,
    input  logic                rd_en,
    input  logic                head_pop,
    output port_wr_pkg::data_t  rd_data,
    output logic                head_valid,
    output port_wr_pkg::port_t  head_port,
    output port_wr_pkg::prior_t head_prior,
    output port_wr_pkg::len_t   head_len,
    output logic                pause
);

    localparam int AW  = $clog2(BUF_DEPTH);
    localparam int QW  = $clog2(HDR_DEPTH);
    localparam int QCW = $clog2(HDR_DEPTH + 1) + 1;

    // pointers carry one extra bit to tell full from empty
    typedef logic [AW:0]    ptr_t;
    typedef logic [QW-1:0]  qidx_t;
    typedef logic [QCW-1:0] qcnt_t;

    // more words in use than this leaves no room for a maximum packet
    localparam ptr_t USED_LIMIT = ptr_t'(BUF_DEPTH - port_wr_pkg::MAX_PKT_WORDS);

    port_wr_pkg::data_t  mem [BUF_DEPTH];
    port_wr_pkg::port_t  q_port [HDR_DEPTH];
    port_wr_pkg::prior_t q_prior [HDR_DEPTH];
    port_wr_pkg::len_t   q_len [HDR_DEPTH];

    ptr_t  rd_ptr;
    ptr_t  wr_ptr_c;
    ptr_t  wr_ptr_u;
    ptr_t  wr_ptr_inc;
    ptr_t  rd_ptr_nxt;
    ptr_t  wr_ptr_c_nxt;
    ptr_t  wr_ptr_u_nxt;
    ptr_t  used_nxt;
    qidx_t q_wr_idx;
    qidx_t q_rd_idx;
    qcnt_t q_cnt;
    qcnt_t q_cnt_nxt;
    qcnt_t q_busy_nxt;
    logic  rx_pending_nxt;
    logic  pause_nxt;

    // a word written in the commit cycle belongs to the committed packet
    assign wr_ptr_inc   = wr_ptr_u + ptr_t'(wr_word_en);
    assign wr_ptr_u_nxt = pkt_drop ? wr_ptr_c : wr_ptr_inc;
    assign wr_ptr_c_nxt = pkt_commit ? wr_ptr_inc : wr_ptr_c;
    assign rd_ptr_nxt   = rd_ptr + ptr_t'(rd_en);
    assign used_nxt     = wr_ptr_u_nxt - rd_ptr_nxt;

    assign q_cnt_nxt = q_cnt + qcnt_t'(pkt_commit) - qcnt_t'(head_pop);

    // a packet still being received holds a queue slot in advance,
    // so a source starting right after its eop cannot overflow the queue
    assign rx_pending_nxt = (wr_ptr_u_nxt != wr_ptr_c_nxt);
    assign q_busy_nxt     = q_cnt_nxt + qcnt_t'(rx_pending_nxt);

    assign pause_nxt = (used_nxt > USED_LIMIT) || (q_busy_nxt >= qcnt_t'(HDR_DEPTH));

    assign head_valid = (q_cnt != '0);
    assign head_port  = q_port[q_rd_idx];
    assign head_prior = q_prior[q_rd_idx];
    assign head_len   = q_len[q_rd_idx];

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            rd_ptr   <= '0;
            wr_ptr_c <= '0;
            wr_ptr_u <= '0;
            pause    <= 1'b0;
        end
        else
        begin
            rd_ptr   <= rd_ptr_nxt;
            wr_ptr_c <= wr_ptr_c_nxt;
            wr_ptr_u <= wr_ptr_u_nxt;
            pause    <= pause_nxt;
        end
    end

    // data memory, one write and one registered read port
    always_ff @(posedge clk)
    begin
        if (wr_word_en)
            mem[wr_ptr_u[AW-1:0]] <= wr_word;
        if (rd_en)
            rd_data <= mem[rd_ptr[AW-1:0]];
    end

    // header queue indices wrap at HDR_DEPTH
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            q_wr_idx <= '0;
            q_rd_idx <= '0;
            q_cnt    <= '0;
        end
        else
        begin
            if (pkt_commit)
            begin
                if (q_wr_idx == qidx_t'(HDR_DEPTH - 1))
                    q_wr_idx <= '0;
                else
                    q_wr_idx <= q_wr_idx + qidx_t'(1);
            end
            if (head_pop)
            begin
                if (q_rd_idx == qidx_t'(HDR_DEPTH - 1))
                    q_rd_idx <= '0;
                else
                    q_rd_idx <= q_rd_idx + qidx_t'(1);
            end
            q_cnt <= q_cnt_nxt;
        end
    end

    always_ff @(posedge clk)
    begin
        if (pkt_commit)
        begin
            q_port[q_wr_idx]  <= hdr_port;
            q_prior[q_wr_idx] <= hdr_prior;
            q_len[q_wr_idx]   <= hdr_len;
        end
    end

endmodule

// ==== hdl/port_wr_xfer_ctrl.sv ====
module port_wr_xfer_ctrl (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                head_valid,
    input  port_wr_pkg::port_t  head_port,
    input  port_wr_pkg::prior_t head_prior,
    input  port_wr_pkg::len_t   head_len,
    input  port_wr_pkg::data_t  rd_data,
    input  logic                match_suc,
    output logic                rd_en,
    output logic                head_pop,
    output logic                match_enable,
    output logic                ready_to_xfer,
    output port_wr_pkg::port_t  new_dest_port,
    output port_wr_pkg::prior_t new_prior,
    output port_wr_pkg::len_t   new_length,
    output port_wr_pkg::data_t  xfer_data,
    output logic                xfer_data_vld,
    output logic                end_of_packet
);

    typedef enum logic [1:0] {
        IDLE,
        REQUEST,
        GRANT,
        STREAM
    } state_t;

    state_t            state;
    port_wr_pkg::len_t rd_cnt;
    logic              rd_last;

    // first read goes out in the grant response cycle, so data starts
    // two cycles after match_suc is seen
    assign rd_en   = (state == GRANT) || (state == STREAM);
    assign rd_last = rd_en && ((rd_cnt + port_wr_pkg::len_t'(1)) == new_length);

    assign match_enable  = (state == REQUEST);
    assign ready_to_xfer = (state == GRANT);
    assign head_pop      = (state == GRANT);

    // buffer read data is already registered
    assign xfer_data = rd_data;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state <= IDLE;
        end
        else
        begin
            case (state)
                IDLE:
                begin
                    if (head_valid)
                        state <= REQUEST;
                end
                REQUEST:
                begin
                    if (match_suc)
                        state <= GRANT;
                end
                GRANT, STREAM:
                begin
                    if (rd_last)
                        state <= IDLE;
                    else
                        state <= STREAM;
                end
                default:
                begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // reads issued so far for the current packet
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            rd_cnt <= '0;
        else if (rd_en)
            rd_cnt <= rd_cnt + port_wr_pkg::len_t'(1);
        else
            rd_cnt <= '0;
    end

    // valid and end flags follow the read by one cycle, like the data
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            xfer_data_vld <= 1'b0;
            end_of_packet <= 1'b0;
        end
        else
        begin
            xfer_data_vld <= rd_en;
            end_of_packet <= rd_last;
        end
    end

    // request fields are held through the grant and the stream
    always_ff @(posedge clk)
    begin
        if ((state == IDLE) && head_valid)
        begin
            new_dest_port <= head_port;
            new_prior     <= head_prior;
            new_length    <= head_len;
        end
    end

endmodule

// ==== hdl/port_wr_frontend.sv ====
module port_wr_frontend #(
    parameter int BUF_DEPTH = port_wr_pkg::BUF_DEPTH_DEF,
    parameter int HDR_DEPTH = port_wr_pkg::HDR_DEPTH_DEF
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                wr_sop,
    input  logic                wr_eop,
    input  logic                wr_vld,
    input  port_wr_pkg::data_t  wr_data,
    input  logic                match_suc,
    output port_wr_pkg::port_t  new_dest_port,
    output port_wr_pkg::prior_t new_prior,
    output port_wr_pkg::len_t   new_length,
    output logic                match_enable,
    output logic                ready_to_xfer,
    output port_wr_pkg::data_t  xfer_data,
    output logic                xfer_data_vld,
    output logic                end_of_packet,
    output logic                pause
);

    // decode to buffer
    port_wr_pkg::data_t  wr_word;
    logic                wr_word_en;
    logic                pkt_commit;
    logic                pkt_drop;
    port_wr_pkg::port_t  hdr_port;
    port_wr_pkg::prior_t hdr_prior;
    port_wr_pkg::len_t   hdr_len;

    // buffer to transfer control
    port_wr_pkg::data_t  rd_data;
    logic                rd_en;
    logic                head_pop;
    logic                head_valid;
    port_wr_pkg::port_t  head_port;
    port_wr_pkg::prior_t head_prior;
    port_wr_pkg::len_t   head_len;

    port_wr_header_decode u_decode (
        .clk        (clk),
        .rst_n      (rst_n),
        .wr_sop     (wr_sop),
        .wr_eop     (wr_eop),
        .wr_vld     (wr_vld),
        .wr_data    (wr_data),
        .wr_word    (wr_word),
        .wr_word_en (wr_word_en),
        .pkt_commit (pkt_commit),
        .pkt_drop   (pkt_drop),
        .hdr_port   (hdr_port),
        .hdr_prior  (hdr_prior),
        .hdr_len    (hdr_len)
    );

    port_wr_packet_buffer #(
        .BUF_DEPTH (BUF_DEPTH),
        .HDR_DEPTH (HDR_DEPTH)
    ) u_execute (
        .clk        (clk),
        .rst_n      (rst_n),
        .wr_word    (wr_word),
        .wr_word_en (wr_word_en),
        .pkt_commit (pkt_commit),
        .pkt_drop   (pkt_drop),
        .hdr_port   (hdr_port),
        .hdr_prior  (hdr_prior),
        .hdr_len    (hdr_len),
        .rd_en      (rd_en),
        .head_pop   (head_pop),
        .rd_data    (rd_data),
        .head_valid (head_valid),
        .head_port  (head_port),
        .head_prior (head_prior),
        .head_len   (head_len),
        .pause      (pause)
    );

    port_wr_xfer_ctrl u_result (
        .clk           (clk),
        .rst_n         (rst_n),
        .head_valid    (head_valid),
        .head_port     (head_port),
        .head_prior    (head_prior),
        .head_len      (head_len),
        .rd_data       (rd_data),
        .match_suc     (match_suc),
        .rd_en         (rd_en),
        .head_pop      (head_pop),
        .match_enable  (match_enable),
        .ready_to_xfer (ready_to_xfer),
        .new_dest_port (new_dest_port),
        .new_prior     (new_prior),
        .new_length    (new_length),
        .xfer_data     (xfer_data),
        .xfer_data_vld (xfer_data_vld),
        .end_of_packet (end_of_packet)
    );

endmodule

// ==== testbench/tb_port_wr_frontend.sv ====
module tb_port_wr_frontend;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int BUF_DEPTH = port_wr_pkg::BUF_DEPTH_DEF;
    localparam int HDR_DEPTH = port_wr_pkg::HDR_DEPTH_DEF;
    localparam int DRV_DLY   = 2;
    localparam int SEED      = 32'h1769;

    logic                clk = 1'b0;
    logic                rst_n;
    logic                wr_sop;
    logic                wr_eop;
    logic                wr_vld;
    port_wr_pkg::data_t  wr_data;
    logic                match_suc;
    port_wr_pkg::port_t  new_dest_port;
    port_wr_pkg::prior_t new_prior;
    port_wr_pkg::len_t   new_length;
    logic                match_enable;
    logic                ready_to_xfer;
    port_wr_pkg::data_t  xfer_data;
    logic                xfer_data_vld;
    logic                end_of_packet;
    logic                pause;

    integer seed;
    integer grant_seed;
    logic   grants_on;

    // the source appends good packets here in send order
    int                  exp_seq[$];
    port_wr_pkg::port_t  exp_port[$];
    port_wr_pkg::prior_t exp_prior[$];
    port_wr_pkg::len_t   exp_len[$];
    int                  pkt_seq  = 0;
    int                  hdr_in   = 0;
    int                  words_in = 0;

    // output side bookkeeping of the monitor
    int hdr_out     = 0;
    int words_out   = 0;
    int since_grant = -1;
    bit req_seen    = 1'b0;
    int cur_seq     = 0;
    int cur_len     = 0;
    int word_idx    = 0;

    port_wr_frontend #(
        .BUF_DEPTH (BUF_DEPTH),
        .HDR_DEPTH (HDR_DEPTH)
    ) dut0 (
        .clk           (clk),
        .rst_n         (rst_n),
        .wr_sop        (wr_sop),
        .wr_eop        (wr_eop),
        .wr_vld        (wr_vld),
        .wr_data       (wr_data),
        .match_suc     (match_suc),
        .new_dest_port (new_dest_port),
        .new_prior     (new_prior),
        .new_length    (new_length),
        .match_enable  (match_enable),
        .ready_to_xfer (ready_to_xfer),
        .xfer_data     (xfer_data),
        .xfer_data_vld (xfer_data_vld),
        .end_of_packet (end_of_packet),
        .pause         (pause)
    );

    always #20 clk = ~clk;

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
            fail_run($sformatf("[FAIL] %0d ns %s got %b expected %b", $time, name, got, exp));
    endtask

    task automatic check_word(input string name, input port_wr_pkg::data_t got,
                              input port_wr_pkg::data_t exp);
        if (got !== exp)
            fail_run($sformatf("[FAIL] %0d ns %s got %h expected %h", $time, name, got, exp));
    endtask

    task automatic check_port(input string name, input port_wr_pkg::port_t got,
                              input port_wr_pkg::port_t exp);
        if (got !== exp)
            fail_run($sformatf("[FAIL] %0d ns %s got %h expected %h", $time, name, got, exp));
    endtask

    task automatic check_prior(input string name, input port_wr_pkg::prior_t got,
                               input port_wr_pkg::prior_t exp);
        if (got !== exp)
            fail_run($sformatf("[FAIL] %0d ns %s got %h expected %h", $time, name, got, exp));
    endtask

    task automatic check_len(input string name, input port_wr_pkg::len_t got,
                             input port_wr_pkg::len_t exp);
        if (got !== exp)
            fail_run($sformatf("[FAIL] %0d ns %s got %0d expected %0d", $time, name, got, exp));
    endtask

    // data word idx of packet seq
    function automatic port_wr_pkg::data_t payload_word(input int seq, input int idx);
        int mix;
        mix = seq * 40503 + idx * 613;
        return port_wr_pkg::data_t'(mix ^ 32'h5a3c);
    endfunction

    task automatic step();
        @(posedge clk);
        #DRV_DLY;
    endtask

    task automatic set_grants(input logic on);
        @(negedge clk);
        grants_on = on;
        step();
    endtask

    task automatic wait_pause_low(input int limit);
        int n;
        n = 0;
        while (pause)
        begin
            if (n == limit)
                fail_run("pause stayed high past the timeout");
            step();
            n++;
        end
    endtask

    task automatic wait_drain(input int limit);
        int n;
        n = 0;
        while ((hdr_out != hdr_in) || (words_out != words_in))
        begin
            if (n == limit)
                fail_run("queued packets did not drain before the timeout");
            step();
            n++;
        end
    endtask

    // pause low must leave room for one more maximum packet;
    // one word may be read already but not yet on xfer_data
    task automatic check_room();
        if (hdr_in - hdr_out >= HDR_DEPTH)
            fail_run("pause was low although the header queue was full");
        if (words_in - words_out + port_wr_pkg::MAX_PKT_WORDS > BUF_DEPTH + 1)
            fail_run("pause was low without room for a maximum size packet");
    endtask

    task automatic send_packet(input int len, input int n_words);
        port_wr_pkg::port_t  port;
        port_wr_pkg::prior_t prior;
        int                  i;
        port  = port_wr_pkg::port_t'($random(seed));
        prior = port_wr_pkg::prior_t'($random(seed));
        check_room();
        wr_sop = 1'b1;
        step();
        wr_sop  = 1'b0;
        wr_vld  = 1'b1;
        wr_data = {port_wr_pkg::len_t'(len), prior, port};
        step();
        for (i = 0; i < n_words; i++)
        begin
            // occasional idle cycle between data words
            if (($random(seed) & 7) == 0)
            begin
                wr_vld = 1'b0;
                step();
            end
            wr_vld  = 1'b1;
            wr_data = payload_word(pkt_seq, i);
            step();
        end
        wr_vld = 1'b0;
        wr_eop = 1'b1;
        if (n_words == len)
        begin
            exp_seq.push_back(pkt_seq);
            exp_port.push_back(port);
            exp_prior.push_back(prior);
            exp_len.push_back(port_wr_pkg::len_t'(len));
            hdr_in   = hdr_in + 1;
            words_in = words_in + len;
        end
        step();
        wr_eop  = 1'b0;
        pkt_seq = pkt_seq + 1;
    endtask

    // mostly short, some long, a few with the wrong word count
    task automatic send_random();
        int pick;
        int len;
        int n_words;
        pick = $random(seed) & 15;
        if (pick == 0)
            len = $random(seed) & 511;
        else
            len = $random(seed) & 15;
        if (len == 0)
            len = 1;
        n_words = len;
        if (pick == 1)
            n_words = len + 1;
        else if (pick == 2)
            n_words = len - 1;
        send_packet(len, n_words);
    endtask

    // grants held back until pause rises, then released
    task automatic fill_while_held(input bit big);
        int n;
        int len;
        set_grants(1'b0);
        n = 0;
        while (!pause && (n < 8))
        begin
            if (big)
                len = 448 + ($random(seed) & 63);
            else
                len = 1 + ($random(seed) & 7);
            send_packet(len, len);
            n++;
        end
        if (!pause)
            fail_run("pause stayed low while grants were held back");
        repeat (10) step();
        // no reads while grants are held back
        check_flag("pause", pause,
                   ((BUF_DEPTH - (words_in - words_out)) < port_wr_pkg::MAX_PKT_WORDS)
                   || ((hdr_in - hdr_out) >= HDR_DEPTH));
        set_grants(1'b1);
        wait_drain(20000);
    endtask

    // grant driver
    initial
    begin
        grant_seed = SEED ^ 32'hffff_ffff;
        match_suc  = 1'b0;
        forever
        begin
            step();
            match_suc = grants_on && match_enable && (($random(grant_seed) & 3) == 0);
        end
    end

    // output monitor
    always @(negedge clk)
    begin
        if (rst_n)
        begin
            if (since_grant >= 0)
                since_grant = since_grant + 1;
            if (since_grant == 1)
            begin
                check_flag("ready_to_xfer", ready_to_xfer, 1'b1);
                check_flag("match_enable", match_enable, 1'b0);
                cur_seq  = exp_seq[hdr_out];
                cur_len  = int'(exp_len[hdr_out]);
                hdr_out  = hdr_out + 1;
                word_idx = 0;
            end
            else
            begin
                check_flag("ready_to_xfer", ready_to_xfer, 1'b0);
            end
            if (since_grant >= 2)
            begin
                check_flag("match_enable", match_enable, 1'b0);
                check_flag("xfer_data_vld", xfer_data_vld, 1'b1);
                check_word("xfer_data", xfer_data, payload_word(cur_seq, word_idx));
                check_flag("end_of_packet", end_of_packet, word_idx == cur_len - 1);
                word_idx  = word_idx + 1;
                words_out = words_out + 1;
                if (word_idx == cur_len)
                    since_grant = -1;
            end
            else
            begin
                check_flag("xfer_data_vld", xfer_data_vld, 1'b0);
                check_flag("end_of_packet", end_of_packet, 1'b0);
            end
            if ((since_grant < 0) && match_enable)
            begin
                if (!req_seen)
                begin
                    if (hdr_out >= exp_len.size())
                        fail_run("match request raised with no good packet pending");
                    check_port("new_dest_port", new_dest_port, exp_port[hdr_out]);
                    check_prior("new_prior", new_prior, exp_prior[hdr_out]);
                    check_len("new_length", new_length, exp_len[hdr_out]);
                    req_seen = 1'b1;
                end
                if (match_suc)
                begin
                    since_grant = 0;
                    req_seen    = 1'b0;
                end
            end
        end
    end

    initial
    begin
        int n;
        seed      = SEED;
        rst_n     = 1'b0;
        wr_sop    = 1'b0;
        wr_eop    = 1'b0;
        wr_vld    = 1'b0;
        wr_data   = '0;
        grants_on = 1'b0;
        repeat (2) @(posedge clk);
        #DRV_DLY;
        rst_n = 1'b1;
        step();
        check_flag("match_enable", match_enable, 1'b0);
        check_flag("xfer_data_vld", xfer_data_vld, 1'b0);
        check_flag("ready_to_xfer", ready_to_xfer, 1'b0);
        check_flag("end_of_packet", end_of_packet, 1'b0);
        check_flag("pause", pause, 1'b0);

        // random traffic with grants running
        set_grants(1'b1);
        for (n = 0; n < 40; n++)
        begin
            wait_pause_low(4000);
            send_random();
            repeat ($random(seed) & 3) step();
        end
        wait_drain(20000);

        // buffer space limit, then header queue limit
        fill_while_held(1'b1);
        fill_while_held(1'b0);

        repeat (5) step();
        if ((hdr_out == 0) || (hdr_out != hdr_in) || (words_out != words_in))
        begin
            fail_run("packets were left over at the end of the run");
        end
        else
        begin
            $display("Simulation PASSED");
            $finish;
        end
    end

endmodule

// ==== verilog.f ====
hdl/port_wr_pkg.sv
hdl/port_wr_header_decode.sv
hdl/port_wr_packet_buffer.sv
hdl/port_wr_xfer_ctrl.sv
hdl/port_wr_frontend.sv
testbench/tb_port_wr_frontend.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the frontend testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --timescale 1ns/100ps \
    --top-module tb_port_wr_frontend \
    -f verilog.f \
    -o sim_port_wr
./obj_dir/sim_port_wr
